// File: hw/tl2umi_settings.svh
`ifndef TL2UMI_SETTINGS_SVH
`define TL2UMI_SETTINGS_SVH

// UMI packet widths
`define TL2UMI_CW 32
`define TL2UMI_AW 64
`define TL2UMI_DW 64

// TileLink side
`define TL2UMI_TL_AW 56
`define TL2UMI_MASK_W 8
`define TL2UMI_SRC_W 5

`define TL2UMI_FIFO_DEPTH 2

// User bits of the request source address
`define TL2UMI_OFS_LSB 32
`define TL2UMI_SIZE_LSB 24
`define TL2UMI_SOURCE_LSB 16

// UMI command fields
`define TL2UMI_EOM_BIT 22

`endif

// File: hw/tl2umi_pkg.sv
`include "tl2umi_settings.svh"

package tl2umi_pkg;

    typedef logic [`TL2UMI_CW-1:0] cmd_t;
    typedef logic [`TL2UMI_AW-1:0] addr_t;
    typedef logic [`TL2UMI_DW-1:0] data_t;
    typedef logic [`TL2UMI_MASK_W-1:0] mask_t;
    typedef logic [`TL2UMI_SRC_W-1:0] source_t;
    typedef logic [2:0] tl_size_t;
    typedef logic [7:0] len_t;
    typedef logic [7:0] bytes_t;
    typedef logic [3:0] offset_t;

    // Channel A opcodes
    typedef enum logic [2:0] {
        TL_PUT_FULL    = 3'd0,
        TL_PUT_PARTIAL = 3'd1,
        TL_GET         = 3'd4
    } tl_op_e;

    // Channel D reuses the same encodings
    localparam tl_op_e TL_ACCESS_ACK = TL_PUT_FULL;
    localparam tl_op_e TL_ACCESS_ACK_DATA = TL_PUT_PARTIAL;

    typedef enum logic [4:0] {
        UMI_REQ_READ   = 5'd1,
        UMI_RESP_READ  = 5'd2,
        UMI_REQ_WRITE  = 5'd3,
        UMI_RESP_WRITE = 5'd4
    } umi_op_e;

    typedef enum logic [2:0] {
        IDLE,
        GET_SEND,
        PUT_BEATS,
        PUT_LAST,
        WAIT_RESP,
        D_OUT
    } seq_state_e;

endpackage

// File: hw/tl2umi_mask_convert.sv
`timescale 1ns/1ps
`include "tl2umi_settings.svh"

module tl2umi_mask_convert (
    input  logic                     clk,
    input  logic                     nreset,
    input  logic                     valid,
    input  tl2umi_pkg::mask_t        mask,
    input  logic [`TL2UMI_TL_AW-1:0] address,
    input  tl2umi_pkg::data_t        data,
    output tl2umi_pkg::offset_t      offset,
    output tl2umi_pkg::len_t         len,
    output tl2umi_pkg::addr_t        ml_addr,
    output tl2umi_pkg::data_t        ml_data
);

    tl2umi_pkg::len_t ones;

    // Lowest set byte, 8 when the mask is empty
    always_comb begin
        offset = 4'd8;
        for (int i = `TL2UMI_MASK_W - 1; i >= 0; i--) begin
            if (mask[i]) begin
                offset = tl2umi_pkg::offset_t'(i);
            end
        end
    end

    always_comb begin
        ones = '0;
        for (int i = 0; i < `TL2UMI_MASK_W; i++) begin
            ones = ones + tl2umi_pkg::len_t'(mask[i]);
        end
    end

    assign len = ones - 8'd1;
    assign ml_addr = {{(`TL2UMI_AW - `TL2UMI_TL_AW){1'b0}},
                      address[`TL2UMI_TL_AW-1:3], offset[2:0]};
    assign ml_data = data >> {offset, 3'b000};

    a_mask_nonzero: assert property (@(posedge clk) disable iff (!nreset)
        valid |-> mask != '0);

endmodule

// File: hw/tl2umi_beat_counter.sv
`timescale 1ns/1ps

module tl2umi_beat_counter (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 load,
    input  tl2umi_pkg::tl_size_t tl_size,
    input  logic                 beat,
    input  tl2umi_pkg::bytes_t   beat_bytes,
    input  logic                 ack,
    input  tl2umi_pkg::bytes_t   ack_bytes,
    output logic                 last_beat,
    output logic                 all_acked
);

    logic [4:0]         remaining;
    logic [4:0]         load_beats;
    tl2umi_pkg::bytes_t req_tally;
    tl2umi_pkg::bytes_t ack_tally;
    tl2umi_pkg::bytes_t ack_sum;

    // One beat per 8 bytes, never fewer than one
    assign load_beats = (tl_size > 3'd3) ? (5'd1 << (tl_size - 3'd3)) : 5'd1;

    assign ack_sum = ack_tally + (ack ? ack_bytes : 8'd0);
    assign all_acked = ack_sum == req_tally;
    assign last_beat = remaining == 5'd1;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            remaining <= '0;
            req_tally <= '0;
            ack_tally <= '0;
        end else begin
            if (load) begin
                remaining <= load_beats - {4'd0, beat};
                req_tally <= beat ? beat_bytes : 8'd0;
                ack_tally <= '0;
            end else begin
                if (beat) begin
                    remaining <= remaining - 5'd1;
                    req_tally <= req_tally + beat_bytes;
                end
                ack_tally <= ack_sum;
            end
        end
    end

    a_ack_le_req: assert property (@(posedge clk) disable iff (!nreset)
        ack_tally <= req_tally);

endmodule

// File: hw/tl2umi_sequencer.sv
`timescale 1ns/1ps
`include "tl2umi_settings.svh"

module tl2umi_sequencer (
    input  logic                  clk,
    input  logic                  nreset,
    input  logic                  tl_a_valid,
    input  logic [2:0]            tl_a_opcode,
    input  tl2umi_pkg::tl_size_t  tl_a_size,
    input  tl2umi_pkg::source_t   tl_a_source,
    input  tl2umi_pkg::offset_t   offset,
    input  tl2umi_pkg::len_t      len,
    input  tl2umi_pkg::addr_t     ml_addr,
    input  tl2umi_pkg::data_t     ml_data,
    input  logic                  pkt_ready,
    input  logic                  last_beat,
    input  logic                  all_acked,
    input  logic                  is_read,
    input  logic                  is_write,
    input  tl2umi_pkg::bytes_t    bytes,
    input  tl2umi_pkg::tl_size_t  size,
    input  tl2umi_pkg::source_t   source,
    input  tl2umi_pkg::data_t     data,
    input  logic                  uhost_resp_valid,
    input  logic                  tl_d_ready,
    output logic                  tl_a_ready,
    output logic                  pkt_valid,
    output tl2umi_pkg::cmd_t      pkt_cmd,
    output tl2umi_pkg::addr_t     pkt_dstaddr,
    output tl2umi_pkg::addr_t     pkt_srcaddr,
    output tl2umi_pkg::data_t     pkt_data,
    output logic                  load,
    output logic                  beat,
    output tl2umi_pkg::bytes_t    beat_bytes,
    output logic                  ack,
    output tl2umi_pkg::bytes_t    ack_bytes,
    output logic                  uhost_resp_ready,
    output logic                  tl_d_valid,
    output logic [2:0]            tl_d_opcode,
    output tl2umi_pkg::tl_size_t  tl_d_size,
    output tl2umi_pkg::source_t   tl_d_source,
    output tl2umi_pkg::data_t     tl_d_data
);

    tl2umi_pkg::seq_state_e state;
    tl2umi_pkg::addr_t      src_user;
    tl2umi_pkg::len_t       get_len;
    logic                   a_fire;
    logic                   a_get;
    logic                   a_put;
    logic                   resp_fire;

    function automatic tl2umi_pkg::cmd_t make_cmd(tl2umi_pkg::umi_op_e op,
                                                  tl2umi_pkg::len_t    n,
                                                  logic                eom);
        tl2umi_pkg::cmd_t c;
        c = '0;
        c[4:0] = op;
        c[15:8] = n;
        c[`TL2UMI_EOM_BIT] = eom;
        return c;
    endfunction

    assign a_get = tl_a_opcode == tl2umi_pkg::TL_GET;
    assign a_put = tl_a_opcode == tl2umi_pkg::TL_PUT_FULL ||
                   tl_a_opcode == tl2umi_pkg::TL_PUT_PARTIAL;

    // One beat at a time through the packet register, so the FIFO always has room
    assign tl_a_ready = (state == tl2umi_pkg::IDLE || state == tl2umi_pkg::PUT_BEATS) &&
                        pkt_ready && !pkt_valid;
    assign a_fire = tl_a_valid && tl_a_ready;

    assign uhost_resp_ready = !tl_d_valid;
    assign resp_fire = uhost_resp_valid && uhost_resp_ready;

    assign load = a_fire && state == tl2umi_pkg::IDLE;
    assign beat = a_fire && a_put;
    assign beat_bytes = len + 8'd1;
    assign ack = resp_fire && is_write;
    assign ack_bytes = bytes;

    assign get_len = tl2umi_pkg::len_t'((9'd1 << tl_a_size) - 9'd1);

    // Offset, size and source ride back in the response address
    always_comb begin
        src_user = '0;
        src_user[`TL2UMI_OFS_LSB +: 4] = offset;
        src_user[`TL2UMI_SIZE_LSB +: 3] = tl_a_size;
        src_user[`TL2UMI_SOURCE_LSB +: `TL2UMI_SRC_W] = tl_a_source;
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state <= tl2umi_pkg::IDLE;
            pkt_valid <= 1'b0;
            tl_d_valid <= 1'b0;
        end else begin
            pkt_valid <= a_fire && (a_get || a_put);
            case (state)
                tl2umi_pkg::IDLE: begin
                    if (a_fire && a_get) begin
                        state <= tl2umi_pkg::GET_SEND;
                    end else if (a_fire && a_put) begin
                        state <= (tl_a_size > 3'd3) ? tl2umi_pkg::PUT_BEATS
                                                    : tl2umi_pkg::PUT_LAST;
                    end
                end
                tl2umi_pkg::PUT_BEATS: begin
                    if (a_fire && last_beat) begin
                        state <= tl2umi_pkg::PUT_LAST;
                    end
                end
                tl2umi_pkg::GET_SEND, tl2umi_pkg::PUT_LAST: begin
                    state <= tl2umi_pkg::WAIT_RESP;
                end
                tl2umi_pkg::WAIT_RESP: begin
                    // Partial write acks only move the tally
                    if (resp_fire && (is_read || (is_write && all_acked))) begin
                        state <= tl2umi_pkg::D_OUT;
                        tl_d_valid <= 1'b1;
                    end
                end
                tl2umi_pkg::D_OUT: begin
                    if (tl_d_ready) begin
                        state <= tl2umi_pkg::IDLE;
                        tl_d_valid <= 1'b0;
                    end
                end
                default: state <= tl2umi_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (a_fire) begin
            pkt_srcaddr <= src_user;
            pkt_data <= ml_data;
            if (state == tl2umi_pkg::IDLE) begin
                pkt_dstaddr <= ml_addr;
                pkt_cmd <= a_get ? make_cmd(tl2umi_pkg::UMI_REQ_READ, get_len, 1'b1)
                                 : make_cmd(tl2umi_pkg::UMI_REQ_WRITE, len, tl_a_size <= 3'd3);
            end else begin
                // Next 8-byte window of the burst
                pkt_dstaddr <= {pkt_dstaddr[`TL2UMI_AW-1:3] + 1'b1, ml_addr[2:0]};
                pkt_cmd <= make_cmd(tl2umi_pkg::UMI_REQ_WRITE, len, last_beat);
            end
        end
        if (resp_fire && state == tl2umi_pkg::WAIT_RESP) begin
            tl_d_opcode <= is_read ? tl2umi_pkg::TL_ACCESS_ACK_DATA : tl2umi_pkg::TL_ACCESS_ACK;
            tl_d_size <= size;
            tl_d_source <= source;
            tl_d_data <= is_read ? data : '0;
        end
    end

    a_d_valid_state: assert property (@(posedge clk) disable iff (!nreset)
        tl_d_valid |-> state == tl2umi_pkg::D_OUT);

    a_pkt_room: assert property (@(posedge clk) disable iff (!nreset)
        pkt_valid |-> pkt_ready);

endmodule

// File: hw/tl2umi_req_fifo.sv
`timescale 1ns/1ps
`include "tl2umi_settings.svh"

module tl2umi_req_fifo #(
    parameter int DEPTH = `TL2UMI_FIFO_DEPTH
) (
    input  logic              clk,
    input  logic              nreset,
    input  logic              wr_en,
    input  tl2umi_pkg::cmd_t  wr_cmd,
    input  tl2umi_pkg::addr_t wr_dstaddr,
    input  tl2umi_pkg::addr_t wr_srcaddr,
    input  tl2umi_pkg::data_t wr_data,
    input  logic              rd_en,
    output logic              full,
    output logic              rd_valid,
    output tl2umi_pkg::cmd_t  rd_cmd,
    output tl2umi_pkg::addr_t rd_dstaddr,
    output tl2umi_pkg::addr_t rd_srcaddr,
    output tl2umi_pkg::data_t rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    tl2umi_pkg::cmd_t  mem_cmd [DEPTH];
    tl2umi_pkg::addr_t mem_dst [DEPTH];
    tl2umi_pkg::addr_t mem_src [DEPTH];
    tl2umi_pkg::data_t mem_data [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              rd_fire;

    assign full = count == CNT_W'(DEPTH);
    assign rd_valid = count != '0;
    assign rd_fire = rd_en && rd_valid;

    assign rd_cmd = mem_cmd[rd_ptr];
    assign rd_dstaddr = mem_dst[rd_ptr];
    assign rd_srcaddr = mem_src[rd_ptr];
    assign rd_data = mem_data[rd_ptr];

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_cmd[wr_ptr] <= wr_cmd;
            mem_dst[wr_ptr] <= wr_dstaddr;
            mem_src[wr_ptr] <= wr_srcaddr;
            mem_data[wr_ptr] <= wr_data;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!nreset)
        wr_en |-> !full);

endmodule

// File: hw/tl2umi_resp_decode.sv
`timescale 1ns/1ps
`include "tl2umi_settings.svh"

module tl2umi_resp_decode (
    input  tl2umi_pkg::cmd_t     cmd,
    input  tl2umi_pkg::addr_t    dstaddr,
    input  tl2umi_pkg::data_t    data,
    output logic                 is_read,
    output logic                 is_write,
    output tl2umi_pkg::bytes_t   bytes,
    output tl2umi_pkg::tl_size_t size,
    output tl2umi_pkg::source_t  source,
    output tl2umi_pkg::data_t    aligned_data
);

    tl2umi_pkg::offset_t offset;

    assign is_read = cmd[4:0] == tl2umi_pkg::UMI_RESP_READ;
    assign is_write = cmd[4:0] == tl2umi_pkg::UMI_RESP_WRITE;

    // Size field is always zero, so len+1 is the byte count
    assign bytes = cmd[15:8] + 8'd1;

    // User bits echoed back from the request source address
    assign size = dstaddr[`TL2UMI_SIZE_LSB +: 3];
    assign source = dstaddr[`TL2UMI_SOURCE_LSB +: `TL2UMI_SRC_W];
    assign offset = dstaddr[`TL2UMI_OFS_LSB +: 4];

    assign aligned_data = data << {offset, 3'b000};

endmodule

// File: hw/tl2umi_top.sv
`timescale 1ns/1ps
`include "tl2umi_settings.svh"

module tl2umi_top (
    input  logic                     clk,
    input  logic                     nreset,
    input  logic                     tl_a_valid,
    output logic                     tl_a_ready,
    input  logic [2:0]               tl_a_opcode,
    input  logic [2:0]               tl_a_param,
    input  tl2umi_pkg::tl_size_t     tl_a_size,
    input  tl2umi_pkg::source_t      tl_a_source,
    input  logic [`TL2UMI_TL_AW-1:0] tl_a_address,
    input  tl2umi_pkg::mask_t        tl_a_mask,
    input  tl2umi_pkg::data_t        tl_a_data,
    output logic                     tl_d_valid,
    input  logic                     tl_d_ready,
    output logic [2:0]               tl_d_opcode,
    output tl2umi_pkg::tl_size_t     tl_d_size,
    output tl2umi_pkg::source_t      tl_d_source,
    output tl2umi_pkg::data_t        tl_d_data,
    output logic                     uhost_req_valid,
    input  logic                     uhost_req_ready,
    output tl2umi_pkg::cmd_t         uhost_req_cmd,
    output tl2umi_pkg::addr_t        uhost_req_dstaddr,
    output tl2umi_pkg::addr_t        uhost_req_srcaddr,
    output tl2umi_pkg::data_t        uhost_req_data,
    input  logic                     uhost_resp_valid,
    output logic                     uhost_resp_ready,
    input  tl2umi_pkg::cmd_t         uhost_resp_cmd,
    input  tl2umi_pkg::addr_t        uhost_resp_dstaddr,
    input  tl2umi_pkg::data_t        uhost_resp_data
);

    tl2umi_pkg::offset_t  offset;
    tl2umi_pkg::len_t     len;
    tl2umi_pkg::addr_t    ml_addr;
    tl2umi_pkg::data_t    ml_data;
    logic                 pkt_valid;
    logic                 pkt_full;
    tl2umi_pkg::cmd_t     pkt_cmd;
    tl2umi_pkg::addr_t    pkt_dstaddr;
    tl2umi_pkg::addr_t    pkt_srcaddr;
    tl2umi_pkg::data_t    pkt_data;
    logic                 load;
    logic                 beat;
    logic                 ack;
    tl2umi_pkg::bytes_t   beat_bytes;
    tl2umi_pkg::bytes_t   ack_bytes;
    logic                 last_beat;
    logic                 all_acked;
    logic                 resp_is_read;
    logic                 resp_is_write;
    tl2umi_pkg::bytes_t   resp_bytes;
    tl2umi_pkg::tl_size_t resp_size;
    tl2umi_pkg::source_t  resp_source;
    tl2umi_pkg::data_t    resp_data;

    tl2umi_mask_convert u_mask_convert (
        .clk(clk), .nreset(nreset), .valid(tl_a_valid),
        .mask(tl_a_mask), .address(tl_a_address), .data(tl_a_data),
        .offset(offset), .len(len), .ml_addr(ml_addr), .ml_data(ml_data)
    );

    tl2umi_sequencer u_sequencer (
        .clk(clk), .nreset(nreset),
        .tl_a_valid(tl_a_valid), .tl_a_opcode(tl_a_opcode),
        .tl_a_size(tl_a_size), .tl_a_source(tl_a_source),
        .offset(offset), .len(len), .ml_addr(ml_addr), .ml_data(ml_data),
        .pkt_ready(!pkt_full), .last_beat(last_beat), .all_acked(all_acked),
        .is_read(resp_is_read), .is_write(resp_is_write), .bytes(resp_bytes),
        .size(resp_size), .source(resp_source), .data(resp_data),
        .uhost_resp_valid(uhost_resp_valid), .tl_d_ready(tl_d_ready),
        .tl_a_ready(tl_a_ready), .pkt_valid(pkt_valid), .pkt_cmd(pkt_cmd),
        .pkt_dstaddr(pkt_dstaddr), .pkt_srcaddr(pkt_srcaddr), .pkt_data(pkt_data),
        .load(load), .beat(beat), .beat_bytes(beat_bytes),
        .ack(ack), .ack_bytes(ack_bytes), .uhost_resp_ready(uhost_resp_ready),
        .tl_d_valid(tl_d_valid), .tl_d_opcode(tl_d_opcode), .tl_d_size(tl_d_size),
        .tl_d_source(tl_d_source), .tl_d_data(tl_d_data)
    );

    tl2umi_beat_counter u_beat_counter (
        .clk(clk), .nreset(nreset), .load(load), .tl_size(tl_a_size),
        .beat(beat), .beat_bytes(beat_bytes), .ack(ack), .ack_bytes(ack_bytes),
        .last_beat(last_beat), .all_acked(all_acked)
    );

    tl2umi_req_fifo u_req_fifo (
        .clk(clk), .nreset(nreset),
        .wr_en(pkt_valid), .wr_cmd(pkt_cmd), .wr_dstaddr(pkt_dstaddr),
        .wr_srcaddr(pkt_srcaddr), .wr_data(pkt_data),
        .rd_en(uhost_req_ready), .full(pkt_full), .rd_valid(uhost_req_valid),
        .rd_cmd(uhost_req_cmd), .rd_dstaddr(uhost_req_dstaddr),
        .rd_srcaddr(uhost_req_srcaddr), .rd_data(uhost_req_data)
    );

    tl2umi_resp_decode u_resp_decode (
        .cmd(uhost_resp_cmd), .dstaddr(uhost_resp_dstaddr), .data(uhost_resp_data),
        .is_read(resp_is_read), .is_write(resp_is_write), .bytes(resp_bytes),
        .size(resp_size), .source(resp_source), .aligned_data(resp_data)
    );

endmodule

// File: verification/tl2umi_tb.sv
`timescale 1ns/1ps
`include "tl2umi_settings.svh"

module tl2umi_tb;

    localparam int NUM_TXN = 200;
    localparam int CYCLES_PER_TXN = 60;
    localparam int MAX_CYCLES = NUM_TXN * CYCLES_PER_TXN;
    localparam logic [`TL2UMI_TL_AW-1:0] ADDR_BASE = 56'h5a_c3f0_1200_0000;

    // TileLink and UMI encodings
    localparam logic [2:0] OP_PUT_FULL = 3'd0;
    localparam logic [2:0] OP_PUT_PARTIAL = 3'd1;
    localparam logic [2:0] OP_GET = 3'd4;
    localparam logic [2:0] OP_ACK = 3'd0;
    localparam logic [2:0] OP_ACK_DATA = 3'd1;
    localparam int UMI_REQ_READ = 1;
    localparam int UMI_RESP_READ = 2;
    localparam int UMI_REQ_WRITE = 3;
    localparam int UMI_RESP_WRITE = 4;

    typedef struct packed {
        logic [2:0]               opcode;
        logic [2:0]               size;
        logic [4:0]               source;
        logic [`TL2UMI_TL_AW-1:0] address;
        logic [7:0]               mask;
        logic [63:0]              data;
    } a_beat_t;

    typedef struct packed {
        logic [31:0] cmd;
        logic [63:0] dstaddr;
        logic [63:0] srcaddr;
        logic [63:0] data;
    } umi_pkt_t;

    typedef struct packed {
        logic [2:0]  opcode;
        logic [2:0]  size;
        logic [4:0]  source;
        logic [63:0] data;
    } d_beat_t;

    logic                     clk;
    logic                     nreset;
    logic                     tl_a_valid;
    logic                     tl_a_ready;
    logic [2:0]               tl_a_opcode;
    logic [2:0]               tl_a_param;
    tl2umi_pkg::tl_size_t     tl_a_size;
    tl2umi_pkg::source_t      tl_a_source;
    logic [`TL2UMI_TL_AW-1:0] tl_a_address;
    tl2umi_pkg::mask_t        tl_a_mask;
    tl2umi_pkg::data_t        tl_a_data;
    logic                     tl_d_valid;
    logic                     tl_d_ready;
    logic [2:0]               tl_d_opcode;
    tl2umi_pkg::tl_size_t     tl_d_size;
    tl2umi_pkg::source_t      tl_d_source;
    tl2umi_pkg::data_t        tl_d_data;
    logic                     uhost_req_valid;
    logic                     uhost_req_ready;
    tl2umi_pkg::cmd_t         uhost_req_cmd;
    tl2umi_pkg::addr_t        uhost_req_dstaddr;
    tl2umi_pkg::addr_t        uhost_req_srcaddr;
    tl2umi_pkg::data_t        uhost_req_data;
    logic                     uhost_resp_valid;
    logic                     uhost_resp_ready;
    tl2umi_pkg::cmd_t         uhost_resp_cmd;
    tl2umi_pkg::addr_t        uhost_resp_dstaddr;
    tl2umi_pkg::data_t        uhost_resp_data;

    a_beat_t     a_beats [$];
    umi_pkt_t    exp_pkts [$];
    umi_pkt_t    host_resps [$];
    d_beat_t     exp_d [$];
    logic [7:0]  ref_mem [logic [63:0]];
    logic [7:0]  host_mem [logic [63:0]];
    logic [31:0] seed;
    int          txn_count;
    int          d_count;
    int          cycle_count;
    logic        busy;

    tl2umi_top u_tl2umi_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int rand16();
        seed = seed * 32'd1103515245 + 32'd12345;
        return int'(seed[30:15]);
    endfunction

    function automatic logic [63:0] rand64();
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < 4; i++) begin
            v = {v[47:0], 16'(rand16())};
        end
        return v;
    endfunction

    // Untouched memory bytes depend on every address bit
    function automatic logic [7:0] fill_byte(input logic [63:0] a);
        logic [7:0] f;
        f = 8'h5c;
        for (int i = 0; i < 8; i++) begin
            f = {f[6:0], f[7]} ^ a[8*i +: 8];
        end
        return f;
    endfunction

    function automatic logic [7:0] ref_byte(input logic [63:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
    endfunction

    function automatic logic [7:0] host_byte(input logic [63:0] a);
        return host_mem.exists(a) ? host_mem[a] : fill_byte(a);
    endfunction

    function automatic logic [31:0] pack_cmd(input int op, input int len, input bit eom);
        logic [31:0] c;
        c = '0;
        c[4:0] = op[4:0];
        c[15:8] = len[7:0];
        c[`TL2UMI_EOM_BIT] = eom;
        return c;
    endfunction

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("error: %s", what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // One TileLink request with its expected UMI packets and D beat
    task automatic gen_txn();
        a_beat_t                  b;
        umi_pkt_t                 p;
        d_beat_t                  d;
        logic [`TL2UMI_TL_AW-1:0] addr;
        logic [63:0]              row;
        bit                       is_get;
        int                       size;
        int                       lane;
        int                       width;
        int                       nbeats;
        int                       lo;
        int                       hi;
        is_get = (rand16() % 5) < 2;
        size = is_get ? rand16() % 4 : rand16() % 6;
        addr = ADDR_BASE + `TL2UMI_TL_AW'((rand16() % 512) & ~((1 << size) - 1));
        width = (size < 3) ? (1 << size) : 8;
        nbeats = (size > 3) ? (1 << (size - 3)) : 1;
        lane = (size < 3) ? int'(addr[2:0]) : 0;
        b.size = 3'(size);
        b.source = 5'(rand16());
        b.address = addr;
        if (is_get) begin
            b.opcode = OP_GET;
        end else begin
            b.opcode = (rand16() % 2 != 0) ? OP_PUT_PARTIAL : OP_PUT_FULL;
        end
        d.opcode = is_get ? OP_ACK_DATA : OP_ACK;
        d.size = b.size;
        d.source = b.source;
        d.data = '0;
        for (int k = 0; k < nbeats; k++) begin
            lo = lane;
            hi = lane + width - 1;
            if (b.opcode == OP_PUT_PARTIAL) begin
                lo = lane + rand16() % width;
                hi = lo + rand16() % (lane + width - lo);
            end
            b.mask = '0;
            for (int j = lo; j <= hi; j++) begin
                b.mask[j] = 1'b1;
            end
            b.data = rand64();
            a_beats.push_back(b);
            row = {8'h00, addr[`TL2UMI_TL_AW-1:3] + 53'(k), 3'b000};
            if (is_get) begin
                p.cmd = pack_cmd(UMI_REQ_READ, (1 << size) - 1, 1'b1);
            end else begin
                p.cmd = pack_cmd(UMI_REQ_WRITE, hi - lo, k == nbeats - 1);
            end
            p.dstaddr = row | 64'(lo);
            p.srcaddr = (64'(lo) << `TL2UMI_OFS_LSB) | (64'(size) << `TL2UMI_SIZE_LSB) |
                        (64'(b.source) << `TL2UMI_SOURCE_LSB);
            p.data = b.data >> (8 * lo);
            exp_pkts.push_back(p);
            for (int j = lo; j <= hi; j++) begin
                if (is_get) begin
                    d.data[8*j +: 8] = ref_byte(row + 64'(j));
                end else begin
                    ref_mem[row + 64'(j)] = b.data[8*j +: 8];
                end
            end
        end
        exp_d.push_back(d);
        txn_count++;
    endtask

    // Host side answers each UMI request
    task automatic host_request(input umi_pkt_t p);
        umi_pkt_t r;
        int       n;
        int       part;
        r = '0;
        r.dstaddr = p.srcaddr;
        n = int'(p.cmd[15:8]) + 1;
        if (int'(p.cmd[4:0]) == UMI_REQ_READ) begin
            for (int i = 0; i < n; i++) begin
                r.data[8*i +: 8] = host_byte(p.dstaddr + 64'(i));
            end
            r.cmd = pack_cmd(UMI_RESP_READ, n - 1, 1'b1);
            host_resps.push_back(r);
        end else begin
            for (int i = 0; i < n; i++) begin
                host_mem[p.dstaddr + 64'(i)] = p.data[8*i +: 8];
            end
            part = 0;
            if (n > 1 && rand16() % 2 != 0) begin
                part = 1 + rand16() % (n - 1);
            end
            if (part != 0) begin
                r.cmd = pack_cmd(UMI_RESP_WRITE, part - 1, 1'b0);
                host_resps.push_back(r);
                r.cmd = pack_cmd(UMI_RESP_WRITE, n - part - 1, 1'b1);
            end else begin
                r.cmd = pack_cmd(UMI_RESP_WRITE, n - 1, 1'b1);
            end
            host_resps.push_back(r);
        end
    endtask

    task automatic drive_inputs();
        a_beat_t  b;
        umi_pkt_t r;
        tl_a_valid = a_beats.size() != 0;
        if (tl_a_valid) begin
            b = a_beats[0];
            tl_a_opcode = b.opcode;
            tl_a_size = b.size;
            tl_a_source = b.source;
            tl_a_address = b.address;
            tl_a_mask = b.mask;
            tl_a_data = b.data;
        end else begin
            tl_a_mask = '0;
        end
        uhost_resp_valid = host_resps.size() != 0;
        if (uhost_resp_valid) begin
            r = host_resps[0];
            uhost_resp_cmd = r.cmd;
            uhost_resp_dstaddr = r.dstaddr;
            uhost_resp_data = r.data;
        end
        uhost_req_ready = (rand16() % 4) != 0;
        tl_d_ready = (rand16() % 4) != 0;
    endtask

    // Handshakes seen here complete on the next rising edge
    task automatic sample_outputs();
        umi_pkt_t e;
        umi_pkt_t p;
        d_beat_t  d;
        if (busy) begin
            check_value("tl_a_ready", 64'(tl_a_ready), 64'd0);
        end
        // A pending D beat blocks further responses
        if (tl_d_valid) begin
            check_value("uhost_resp_ready", 64'(uhost_resp_ready), 64'd0);
        end
        if (tl_a_valid && tl_a_ready) begin
            void'(a_beats.pop_front());
            if (a_beats.size() == 0) begin
                busy = 1'b1;
                if (txn_count < NUM_TXN) begin
                    gen_txn();
                end
            end
        end
        if (uhost_req_valid && uhost_req_ready) begin
            if (exp_pkts.size() == 0) begin
                report_error("a UMI request came out with none expected");
            end else begin
                e = exp_pkts.pop_front();
                check_value("uhost_req_cmd", 64'(uhost_req_cmd), 64'(e.cmd));
                check_value("uhost_req_dstaddr", uhost_req_dstaddr, e.dstaddr);
                check_value("uhost_req_srcaddr", uhost_req_srcaddr, e.srcaddr);
                check_value("uhost_req_data", uhost_req_data, e.data);
                p.cmd = uhost_req_cmd;
                p.dstaddr = uhost_req_dstaddr;
                p.srcaddr = uhost_req_srcaddr;
                p.data = uhost_req_data;
                host_request(p);
            end
        end
        if (uhost_resp_valid && uhost_resp_ready) begin
            void'(host_resps.pop_front());
        end
        if (tl_d_valid && tl_d_ready) begin
            if (exp_d.size() == 0) begin
                report_error("a D response came with no request outstanding");
            end else begin
                d = exp_d.pop_front();
                check_value("tl_d_opcode", 64'(tl_d_opcode), 64'(d.opcode));
                check_value("tl_d_size", 64'(tl_d_size), 64'(d.size));
                check_value("tl_d_source", 64'(tl_d_source), 64'(d.source));
                if (d.opcode == OP_ACK_DATA) begin
                    check_value("tl_d_data", tl_d_data, d.data);
                end
                d_count++;
                busy = 1'b0;
            end
        end
    endtask

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > MAX_CYCLES) begin
                report_error("timeout, the run did not finish within the cycle limit");
            end
        end
    end

    initial begin
        seed = 32'd8;
        txn_count = 0;
        d_count = 0;
        busy = 1'b0;
        nreset = 1'b0;
        tl_a_valid = 1'b0;
        tl_a_opcode = '0;
        tl_a_param = '0;
        tl_a_size = '0;
        tl_a_source = '0;
        tl_a_address = '0;
        tl_a_mask = '0;
        tl_a_data = '0;
        tl_d_ready = 1'b0;
        uhost_req_ready = 1'b0;
        uhost_resp_valid = 1'b0;
        uhost_resp_cmd = '0;
        uhost_resp_dstaddr = '0;
        uhost_resp_data = '0;
        repeat (4) @(posedge clk);
        #2 nreset = 1'b1;
        @(negedge clk);
        check_value("tl_a_ready", 64'(tl_a_ready), 64'd1);
        check_value("tl_d_valid", 64'(tl_d_valid), 64'd0);
        check_value("uhost_req_valid", 64'(uhost_req_valid), 64'd0);
        check_value("uhost_resp_ready", 64'(uhost_resp_ready), 64'd1);
        gen_txn();
        while (d_count < NUM_TXN) begin
            @(posedge clk);
            #2;
            drive_inputs();
            @(negedge clk);
            sample_outputs();
        end
        if (exp_pkts.size() != 0 || host_resps.size() != 0) begin
            report_error("UMI traffic was left over after the last D response");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+hw
hw/tl2umi_pkg.sv
hw/tl2umi_mask_convert.sv
hw/tl2umi_beat_counter.sv
hw/tl2umi_sequencer.sv
hw/tl2umi_req_fifo.sv
hw/tl2umi_resp_decode.sv
hw/tl2umi_top.sv
verification/tl2umi_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f build.f --top-module tl2umi_tb -j 0

./obj_dir/Vtl2umi_tb 2>&1 | tee sim.log

grep -q "PASS: all tests" sim.log
echo "simulation passed"
